//--- src/dualIssuePkg.sv
package dualIssuePkg;

    // alu operation codes
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10  // lui passes the immediate straight through
    } aluOp;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immU = 3'd3,
        immJ = 3'd4
    } immKind;

    typedef enum logic [1:0] {
        resAlu = 2'd0,
        resMem = 2'd1,
        resPc4 = 2'd2  // link address for jal/jalr
    } resultSel;

    typedef enum logic [1:0] {
        jumpNone = 2'd0,
        jumpJal  = 2'd1,
        jumpJalr = 2'd2
    } jumpKind;

    typedef struct packed {
        logic       regWrite;
        resultSel   resultSrc;
        logic       memWrite;
        jumpKind    jump;
        logic       branch;
        logic [2:0] branchType;         // funct3 of the branch
        aluOp       aluControl;
        logic       aluSrcA;            // 1 selects pc
        logic       aluSrcB;            // 1 selects immediate
        immKind     immSrc;
        logic [2:0] addressingControl;  // load/store width and sign
    } ctrlSignals;

    // everything execute needs for one slot
    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] rdata1;
        logic [31:0] rdata2;
        logic [31:0] immExt;
        ctrlSignals  ctrl;
    } slotDecode;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } regWritePort;

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

endpackage

//--- src/instrControl.sv
`timescale 1ns/1ns

module instrControl (
    input  logic [6:0]              opcode,
    input  logic [2:0]              funct3,
    input  logic [6:0]              funct7,
    output dualIssuePkg::ctrlSignals ctrl
);

    // funct3 picks the operation, alt selects sub/sra
    function automatic dualIssuePkg::aluOp aluFromFunct(
        input logic [2:0] f3,
        input logic       alt
    );
        dualIssuePkg::aluOp op;
        case (f3)
            3'b000: begin
                if (alt) op = dualIssuePkg::aluSub;
                else     op = dualIssuePkg::aluAdd;
            end
            3'b001: op = dualIssuePkg::aluSll;
            3'b010: op = dualIssuePkg::aluSlt;
            3'b011: op = dualIssuePkg::aluSltu;
            3'b100: op = dualIssuePkg::aluXor;
            3'b101: begin
                if (alt) op = dualIssuePkg::aluSra;
                else     op = dualIssuePkg::aluSrl;
            end
            3'b110: op = dualIssuePkg::aluOr;
            default: op = dualIssuePkg::aluAnd;
        endcase
        return op;
    endfunction

    logic immShiftAlt;  // srai is the only op-imm that looks at funct7

    assign immShiftAlt = (funct3 == 3'b101) && funct7[5];

    always_comb begin
        ctrl = '0;  // unknown opcodes fall out as a no-op
        case (opcode)
            dualIssuePkg::opLoad: begin
                ctrl.regWrite          = 1'b1;
                ctrl.resultSrc         = dualIssuePkg::resMem;
                ctrl.aluSrcB           = 1'b1;
                ctrl.immSrc            = dualIssuePkg::immI;
                ctrl.aluControl        = dualIssuePkg::aluAdd;  // address calc
                ctrl.addressingControl = funct3;
            end
            dualIssuePkg::opStore: begin
                ctrl.memWrite          = 1'b1;
                ctrl.aluSrcB           = 1'b1;
                ctrl.immSrc            = dualIssuePkg::immS;
                ctrl.aluControl        = dualIssuePkg::aluAdd;
                ctrl.addressingControl = funct3;
            end
            dualIssuePkg::opBranch: begin
                ctrl.branch     = 1'b1;
                ctrl.branchType = funct3;
                ctrl.immSrc     = dualIssuePkg::immB;
                ctrl.aluControl = dualIssuePkg::aluSub;  // compare operands
            end
            dualIssuePkg::opJal: begin
                ctrl.regWrite   = 1'b1;
                ctrl.resultSrc  = dualIssuePkg::resPc4;
                ctrl.jump       = dualIssuePkg::jumpJal;
                ctrl.aluSrcA    = 1'b1;  // target is pc + imm
                ctrl.aluSrcB    = 1'b1;
                ctrl.immSrc     = dualIssuePkg::immJ;
                ctrl.aluControl = dualIssuePkg::aluAdd;
            end
            dualIssuePkg::opJalr: begin
                ctrl.regWrite   = 1'b1;
                ctrl.resultSrc  = dualIssuePkg::resPc4;
                ctrl.jump       = dualIssuePkg::jumpJalr;
                ctrl.aluSrcB    = 1'b1;  // target is rs1 + imm
                ctrl.immSrc     = dualIssuePkg::immI;
                ctrl.aluControl = dualIssuePkg::aluAdd;
            end
            dualIssuePkg::opOpImm: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcB    = 1'b1;
                ctrl.immSrc     = dualIssuePkg::immI;
                ctrl.aluControl = aluFromFunct(funct3, immShiftAlt);
            end
            dualIssuePkg::opOp: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = aluFromFunct(funct3, funct7[5]);
            end
            dualIssuePkg::opLui: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcB    = 1'b1;
                ctrl.immSrc     = dualIssuePkg::immU;
                ctrl.aluControl = dualIssuePkg::aluPassB;
            end
            dualIssuePkg::opAuipc: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcA    = 1'b1;
                ctrl.aluSrcB    = 1'b1;
                ctrl.immSrc     = dualIssuePkg::immU;
                ctrl.aluControl = dualIssuePkg::aluAdd;
            end
            default: begin
                ctrl = '0;  // fence, system and anything else
            end
        endcase
    end

endmodule

//--- src/immExtend.sv
`timescale 1ns/1ns

// imm holds instruction bits 31..7, so instr[k] sits at imm[k-7]
module immExtend (
    input  logic [24:0]          imm,
    input  dualIssuePkg::immKind immSrc,
    output logic [31:0]          immExt
);

    logic sign;  // instruction bit 31

    assign sign = imm[24];

    always_comb begin
        case (immSrc)
            dualIssuePkg::immI: begin
                immExt = {{20{sign}}, imm[24:13]};
            end
            dualIssuePkg::immS: begin
                immExt = {{20{sign}}, imm[24:18], imm[4:0]};
            end
            dualIssuePkg::immB: begin
                // instr[31], instr[7], instr[30:25], instr[11:8]
                immExt = {{19{sign}}, sign, imm[0], imm[23:18], imm[4:1], 1'b0};
            end
            dualIssuePkg::immU: begin
                immExt = {imm[24:5], 12'b0};
            end
            dualIssuePkg::immJ: begin
                // instr[31], instr[19:12], instr[20], instr[30:21]
                immExt = {{11{sign}}, sign, imm[12:5], imm[13], imm[23:14], 1'b0};
            end
            default: begin
                immExt = '0;
            end
        endcase
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic                      clk,
    input  logic [4:0]                rAddr1,
    input  logic [4:0]                rAddr2,
    input  logic [4:0]                rAddr4,
    input  logic [4:0]                rAddr5,
    input  dualIssuePkg::regWritePort wb1,
    input  dualIssuePkg::regWritePort wb2,
    output logic [31:0]               rData1,
    output logic [31:0]               rData2,
    output logic [31:0]               rData4,
    output logic [31:0]               rData5,
    output logic [31:0]               a0,
    output logic [31:0]               a1
);

    logic [31:0] regs [1:31];  // x0 has no storage

    // slot 2 is later in program order, so its write lands last
    always_ff @(posedge clk) begin
        if (wb1.en && (wb1.addr != 5'd0)) begin
            regs[wb1.addr] <= wb1.data;
        end
        if (wb2.en && (wb2.addr != 5'd0)) begin
            regs[wb2.addr] <= wb2.data;
        end
    end

    function automatic logic [31:0] readReg(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rData1 = readReg(rAddr1);  // slot 1 rs1
        rData2 = readReg(rAddr2);  // slot 1 rs2
        rData4 = readReg(rAddr4);  // slot 2 rs1
        rData5 = readReg(rAddr5);  // slot 2 rs2
    end

    // abi return registers, watched by the testbench
    assign a0 = regs[10];
    assign a1 = regs[11];

endmodule

//--- src/issueHazardUnit.sv
`timescale 1ns/1ns

module issueHazardUnit (
    input  logic                     clk,
    input  logic                     rstN,
    input  dualIssuePkg::ctrlSignals slot1Ctrl,
    input  logic [4:0]               slot1Rd,
    input  logic [6:0]               slot2Opcode,
    input  logic [4:0]               slot2Rs1,
    input  logic [4:0]               slot2Rs2,
    input  logic [4:0]               slot2Rd,
    input  logic                     slot2RegWrite,
    output logic                     stallSlot2,
    output logic                     holdSlot1Next
);

    logic usesRs1;
    logic usesRs2;
    logic slot1Writes;
    logic ctrlHazard;
    logic rawHazard;
    logic wawHazard;

    // field bits are garbage for formats that have no such source
    assign usesRs1 = !((slot2Opcode == dualIssuePkg::opLui)   ||
                       (slot2Opcode == dualIssuePkg::opAuipc) ||
                       (slot2Opcode == dualIssuePkg::opJal));
    assign usesRs2 = (slot2Opcode == dualIssuePkg::opOp)    ||
                     (slot2Opcode == dualIssuePkg::opStore) ||
                     (slot2Opcode == dualIssuePkg::opBranch);

    assign slot1Writes = slot1Ctrl.regWrite && (slot1Rd != 5'd0);  // x0 never conflicts

    // slot 2 may be on the wrong path behind a control transfer
    assign ctrlHazard = slot1Ctrl.branch || (slot1Ctrl.jump != dualIssuePkg::jumpNone);

    assign rawHazard = slot1Writes &&
                       ((usesRs1 && (slot2Rs1 == slot1Rd)) ||
                        (usesRs2 && (slot2Rs2 == slot1Rd)));

    assign wawHazard = slot1Writes && slot2RegWrite && (slot2Rd == slot1Rd);

    assign stallSlot2 = ctrlHazard || rawHazard || wawHazard;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            holdSlot1Next <= 1'b0;
        end else begin
            holdSlot1Next <= stallSlot2;  // slot 1 waits while slot 2 reissues
        end
    end

endmodule

//--- src/dualDecode.sv
`timescale 1ns/1ns

module dualDecode (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [31:0]               instr1,
    input  logic [31:0]               instr2,
    input  dualIssuePkg::regWritePort wb1,
    input  dualIssuePkg::regWritePort wb2,
    output dualIssuePkg::slotDecode   slot1,
    output dualIssuePkg::slotDecode   slot2,
    output logic                      stallSlot2,
    output logic                      holdSlot1Next,
    output logic [31:0]               a0,
    output logic [31:0]               a1
);

    logic [4:0]  rs1A, rs2A, rdA;  // slot 1 fields
    logic [4:0]  rs1B, rs2B, rdB;  // slot 2 fields
    logic [31:0] rData1, rData2, rData4, rData5;
    logic [31:0] immExt1, immExt2;

    dualIssuePkg::ctrlSignals ctrl1;
    dualIssuePkg::ctrlSignals ctrl2;

    assign rs1A = instr1[19:15];
    assign rs2A = instr1[24:20];
    assign rdA  = instr1[11:7];
    assign rs1B = instr2[19:15];
    assign rs2B = instr2[24:20];
    assign rdB  = instr2[11:7];

    instrControl ctrlDec1 (
        .opcode (instr1[6:0]),
        .funct3 (instr1[14:12]),
        .funct7 (instr1[31:25]),
        .ctrl   (ctrl1)
    );

    instrControl ctrlDec2 (
        .opcode (instr2[6:0]),
        .funct3 (instr2[14:12]),
        .funct7 (instr2[31:25]),
        .ctrl   (ctrl2)
    );

    immExtend immGen1 (.imm(instr1[31:7]), .immSrc(ctrl1.immSrc), .immExt(immExt1));
    immExtend immGen2 (.imm(instr2[31:7]), .immSrc(ctrl2.immSrc), .immExt(immExt2));

    regFile regs (
        .clk    (clk),
        .rAddr1 (rs1A),
        .rAddr2 (rs2A),
        .rAddr4 (rs1B),
        .rAddr5 (rs2B),
        .wb1    (wb1),
        .wb2    (wb2),
        .rData1 (rData1),
        .rData2 (rData2),
        .rData4 (rData4),
        .rData5 (rData5),
        .a0     (a0),
        .a1     (a1)
    );

    issueHazardUnit hazard (
        .clk           (clk),
        .rstN          (rstN),
        .slot1Ctrl     (ctrl1),
        .slot1Rd       (rdA),
        .slot2Opcode   (instr2[6:0]),
        .slot2Rs1      (rs1B),
        .slot2Rs2      (rs2B),
        .slot2Rd       (rdB),
        .slot2RegWrite (ctrl2.regWrite),
        .stallSlot2    (stallSlot2),
        .holdSlot1Next (holdSlot1Next)
    );

    // operands come from read ports 1/2 for slot 1 and 4/5 for slot 2
    assign slot1 = '{rs1: rs1A, rs2: rs2A, rd: rdA,
                     rdata1: rData1, rdata2: rData2,
                     immExt: immExt1, ctrl: ctrl1};

    assign slot2 = '{rs1: rs1B, rs2: rs2B, rd: rdB,
                     rdata1: rData4, rdata2: rData5,
                     immExt: immExt2, ctrl: ctrl2};

endmodule

//--- bench/dualDecodeTb.sv
`timescale 1ns/1ns

module dualDecodeTb;

    localparam int resetCycles = 5;
    localparam int numRandom   = 300;
    localparam int testCycles  = resetCycles + 17 + 2 + 11 + numRandom + 2;
    localparam int maxCycles   = testCycles + 200;
    localparam logic [31:0] nop = 32'h00000013;  // addi x0, x0, 0

    logic                      clk = 1'b0;
    logic                      rstN;
    logic [31:0]               instr1;
    logic [31:0]               instr2;
    dualIssuePkg::regWritePort wb1;
    dualIssuePkg::regWritePort wb2;
    dualIssuePkg::slotDecode   slot1;
    dualIssuePkg::slotDecode   slot2;
    logic                      stallSlot2;
    logic                      holdSlot1Next;
    logic [31:0]               a0;
    logic [31:0]               a1;

    logic [31:0] shadow [0:31];  // expected register contents
    logic        known [0:31];   // register written since reset
    logic [31:0] rngState = 32'd43;
    logic        prevStall = 1'b0;
    int          cycleCount = 0;
    int          ctrlErrors = 0;
    int          wordErrors = 0;
    int          flagErrors = 0;

    dualDecode u_dut (
        .clk           (clk),
        .rstN          (rstN),
        .instr1        (instr1),
        .instr2        (instr2),
        .wb1           (wb1),
        .wb2           (wb2),
        .slot1         (slot1),
        .slot2         (slot2),
        .stallSlot2    (stallSlot2),
        .holdSlot1Next (holdSlot1Next),
        .a0            (a0),
        .a1            (a1)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // expected control word from the rv32i opcode table
    function automatic dualIssuePkg::ctrlSignals refCtrl(input logic [31:0] ins);
        dualIssuePkg::ctrlSignals c;
        logic [6:0] op;
        logic [2:0] f3;
        logic       isOp;
        logic       alt;
        op = ins[6:0];
        f3 = ins[14:12];
        isOp = (op == dualIssuePkg::opOp);
        c = '0;
        if (op inside {dualIssuePkg::opLoad, dualIssuePkg::opStore, dualIssuePkg::opBranch,
                       dualIssuePkg::opJal, dualIssuePkg::opJalr, dualIssuePkg::opOpImm,
                       dualIssuePkg::opOp, dualIssuePkg::opLui, dualIssuePkg::opAuipc}) begin
            c.regWrite = (op != dualIssuePkg::opStore) && (op != dualIssuePkg::opBranch);
            c.memWrite = (op == dualIssuePkg::opStore);
            c.branch   = (op == dualIssuePkg::opBranch);
            c.aluSrcA  = (op == dualIssuePkg::opJal) || (op == dualIssuePkg::opAuipc);
            c.aluSrcB  = !isOp && (op != dualIssuePkg::opBranch);
            if (c.branch) c.branchType = f3;
            if (op == dualIssuePkg::opLoad || op == dualIssuePkg::opStore) begin
                c.addressingControl = f3;
            end
            if (op == dualIssuePkg::opLoad) c.resultSrc = dualIssuePkg::resMem;
            if (op == dualIssuePkg::opJal || op == dualIssuePkg::opJalr) begin
                c.resultSrc = dualIssuePkg::resPc4;
            end
            if (op == dualIssuePkg::opJal)  c.jump = dualIssuePkg::jumpJal;
            if (op == dualIssuePkg::opJalr) c.jump = dualIssuePkg::jumpJalr;
            case (op)
                dualIssuePkg::opStore:  c.immSrc = dualIssuePkg::immS;
                dualIssuePkg::opBranch: c.immSrc = dualIssuePkg::immB;
                dualIssuePkg::opLui:    c.immSrc = dualIssuePkg::immU;
                dualIssuePkg::opAuipc:  c.immSrc = dualIssuePkg::immU;
                dualIssuePkg::opJal:    c.immSrc = dualIssuePkg::immJ;
                default:                c.immSrc = dualIssuePkg::immI;
            endcase
            c.aluControl = dualIssuePkg::aluAdd;  // address and link arithmetic
            if (op == dualIssuePkg::opBranch) c.aluControl = dualIssuePkg::aluSub;
            if (op == dualIssuePkg::opLui)    c.aluControl = dualIssuePkg::aluPassB;
            if (isOp || op == dualIssuePkg::opOpImm) begin
                alt = ins[30] && ((f3 == 3'd5) || (isOp && f3 == 3'd0));  // no subi in rv32i
                case (f3)
                    3'd0: if (alt) c.aluControl = dualIssuePkg::aluSub;
                          else     c.aluControl = dualIssuePkg::aluAdd;
                    3'd1: c.aluControl = dualIssuePkg::aluSll;
                    3'd2: c.aluControl = dualIssuePkg::aluSlt;
                    3'd3: c.aluControl = dualIssuePkg::aluSltu;
                    3'd4: c.aluControl = dualIssuePkg::aluXor;
                    3'd5: if (alt) c.aluControl = dualIssuePkg::aluSra;
                          else     c.aluControl = dualIssuePkg::aluSrl;
                    3'd6: c.aluControl = dualIssuePkg::aluOr;
                    default: c.aluControl = dualIssuePkg::aluAnd;
                endcase
            end
        end
        return c;
    endfunction

    function automatic logic [31:0] refImm(input logic [31:0] ins);
        logic [31:0] imm;
        case (ins[6:0])
            dualIssuePkg::opStore:  imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            dualIssuePkg::opBranch: imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            dualIssuePkg::opLui:    imm = {ins[31:12], 12'b0};
            dualIssuePkg::opAuipc:  imm = {ins[31:12], 12'b0};
            dualIssuePkg::opJal:    imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default:                imm = {{20{ins[31]}}, ins[31:20]};
        endcase
        return imm;
    endfunction

    function automatic logic refStall(input logic [31:0] i1, input logic [31:0] i2);
        dualIssuePkg::ctrlSignals c1;
        dualIssuePkg::ctrlSignals c2;
        logic [6:0] op1;
        logic [6:0] op2;
        logic       writes1;
        logic       readsA;
        logic       readsB;
        op1 = i1[6:0];
        op2 = i2[6:0];
        c1 = refCtrl(i1);
        c2 = refCtrl(i2);
        writes1 = c1.regWrite && (i1[11:7] != 5'd0);
        readsA = !(op2 inside {dualIssuePkg::opLui, dualIssuePkg::opAuipc, dualIssuePkg::opJal});
        readsB = op2 inside {dualIssuePkg::opOp, dualIssuePkg::opStore, dualIssuePkg::opBranch};
        return (op1 inside {dualIssuePkg::opBranch, dualIssuePkg::opJal, dualIssuePkg::opJalr})
            || (writes1 && readsA && (i2[19:15] == i1[11:7]))
            || (writes1 && readsB && (i2[24:20] == i1[11:7]))
            || (writes1 && c2.regWrite && (i2[11:7] == i1[11:7]));
    endfunction

    // random instruction with legal funct fields for one of the nine opcodes
    function automatic logic [31:0] randInstr();
        logic [31:0] r;
        logic [31:0] pick;
        logic [31:0] v;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r = nextRand();
        pick = nextRand();
        f3 = r[14:12];
        f7 = r[31:25];
        case (pick % 9)
            0: begin
                op = dualIssuePkg::opOp;
                f7 = ((f3 == 3'd0) || (f3 == 3'd5)) ? {1'b0, r[30], 5'b0} : 7'b0;
            end
            1: begin
                op = dualIssuePkg::opOpImm;
                if (f3 == 3'd1)      f7 = 7'b0;  // slli
                else if (f3 == 3'd5) f7 = {1'b0, r[30], 5'b0};
            end
            2: begin
                op = dualIssuePkg::opLoad;
                v = pick[8:6] % 5;
                if (v > 2) v = v + 1;  // lb lh lw lbu lhu
                f3 = v[2:0];
            end
            3: begin
                op = dualIssuePkg::opStore;
                v = pick[8:6] % 3;
                f3 = v[2:0];
            end
            4: begin
                op = dualIssuePkg::opBranch;
                v = pick[8:6] % 6;
                if (v >= 2) v = v + 2;  // skip the two reserved codes
                f3 = v[2:0];
            end
            5: begin
                op = dualIssuePkg::opJalr;
                f3 = 3'd0;
            end
            6: op = dualIssuePkg::opJal;
            7: op = dualIssuePkg::opLui;
            default: op = dualIssuePkg::opAuipc;
        endcase
        return {f7, r[24:15], f3, r[11:7], op};
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rd, rs1, rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, dualIssuePkg::opOp};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] op, input logic [4:0] rd, rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, 3'b0, rd, op};
    endfunction

    function automatic dualIssuePkg::regWritePort wbPort(input logic en, input logic [4:0] addr,
                                                         input logic [31:0] data);
        dualIssuePkg::regWritePort p;
        p.en = en;
        p.addr = addr;
        p.data = data;
        return p;
    endfunction

    function automatic logic isKnown(input logic [4:0] addr);
        return (addr == 5'd0) || known[addr];
    endfunction

    function automatic logic [31:0] shadowRead(input logic [4:0] addr);
        return (addr == 5'd0) ? 32'd0 : shadow[addr];
    endfunction

    task automatic checkCtrl(input dualIssuePkg::ctrlSignals got, exp, input string what);
        if (got !== exp) begin
            ctrlErrors++;
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkWord(input logic [31:0] got, exp, input string what);
        if (got !== exp) begin
            wordErrors++;
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input logic got, exp, input string what);
        if (got !== exp) begin
            flagErrors++;
            $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkSlot(input dualIssuePkg::slotDecode s, input logic [31:0] ins,
                             input string tag);
        checkCtrl(s.ctrl, refCtrl(ins), {tag, " ctrl"});
        checkWord(s.immExt, refImm(ins), {tag, " immExt"});
        checkWord({17'b0, s.rs1, s.rs2, s.rd}, {17'b0, ins[19:15], ins[24:20], ins[11:7]},
                  {tag, " register fields"});
        if (isKnown(ins[19:15])) checkWord(s.rdata1, shadowRead(ins[19:15]), {tag, " rdata1"});
        if (isKnown(ins[24:20])) checkWord(s.rdata2, shadowRead(ins[24:20]), {tag, " rdata2"});
    endtask

    task automatic driveCycle(input logic [31:0] i1, i2, input dualIssuePkg::regWritePort w1, w2);
        @(posedge clk);
        instr1 <= i1;
        instr2 <= i2;
        wb1 <= w1;
        wb2 <= w2;
    endtask

    task automatic directedPair(input logic [31:0] i1, i2, input logic expStall, input string what);
        driveCycle(i1, i2, '0, '0);
        @(negedge clk);
        checkFlag(stallSlot2, expStall, what);
    endtask

    // shadow register file where wb2 is assigned last and wins a conflict
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) known[i] <= 1'b0;
        end else begin
            if (wb1.en && wb1.addr != 5'd0) begin
                shadow[wb1.addr] <= wb1.data;
                known[wb1.addr] <= 1'b1;
            end
            if (wb2.en && wb2.addr != 5'd0) begin
                shadow[wb2.addr] <= wb2.data;
                known[wb2.addr] <= 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rstN) begin
            checkFlag(holdSlot1Next, 1'b0, "holdSlot1Next in reset");
            prevStall = 1'b0;
        end else begin
            checkSlot(slot1, instr1, "slot1");
            checkSlot(slot2, instr2, "slot2");
            checkFlag(stallSlot2, refStall(instr1, instr2), "stallSlot2");
            checkFlag(holdSlot1Next, prevStall, "holdSlot1Next");
            prevStall = stallSlot2;
            if (known[10]) checkWord(a0, shadow[10], "a0");
            if (known[11]) checkWord(a1, shadow[11], "a1");
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [4:0] addrA;
        logic [4:0] addrB;
        rstN <= 1'b0;
        instr1 <= nop;
        instr2 <= nop;
        wb1 <= '0;
        wb2 <= '0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        // fill every register and read back last cycle's pair on all four ports
        for (int k = 0; k < 17; k++) begin
            addrA = 5'(2 * k + 1);
            addrB = 5'(2 * k + 2);  // last pair wraps to x0
            driveCycle(rType(5'd0, addrA - 5'd2, addrA - 5'd1),
                       rType(5'd0, addrA - 5'd1, addrA - 5'd2),
                       wbPort(k < 16, addrA, nextRand()), wbPort(k < 16, addrB, nextRand()));
        end

        driveCycle(nop, nop, wbPort(1'b1, 5'd7, 32'h1111_aaaa), wbPort(1'b1, 5'd7, 32'h2222_bbbb));
        driveCycle(rType(5'd0, 5'd7, 5'd7), rType(5'd0, 5'd7, 5'd0), '0, '0);
        @(negedge clk);
        checkWord(slot1.rdata1, 32'h2222_bbbb, "write conflict");

        directedPair(rType(5'd5, 5'd1, 5'd2), rType(5'd3, 5'd5, 5'd4), 1'b1, "raw rs1");
        directedPair(rType(5'd5, 5'd1, 5'd2), rType(5'd3, 5'd4, 5'd5), 1'b1, "raw rs2");
        directedPair(rType(5'd5, 5'd1, 5'd2), iType(dualIssuePkg::opOpImm, 5'd3, 5'd4, 12'h005),
                     1'b0, "op-imm rs2 field");
        directedPair(rType(5'd0, 5'd1, 5'd2), rType(5'd3, 5'd0, 5'd0), 1'b0, "rd x0");
        directedPair(rType(5'd5, 5'd1, 5'd2), iType(dualIssuePkg::opOpImm, 5'd5, 5'd1, 12'h001),
                     1'b1, "waw");
        directedPair({7'b0, 5'd2, 5'd1, 3'b0, 5'b0, dualIssuePkg::opBranch},
                     rType(5'd3, 5'd4, 5'd6), 1'b1, "branch in slot 1");
        directedPair({20'b0, 5'd1, dualIssuePkg::opJal}, rType(5'd3, 5'd4, 5'd6), 1'b1,
                     "jal in slot 1");
        directedPair(iType(dualIssuePkg::opJalr, 5'd1, 5'd2, 12'h0), rType(5'd3, 5'd4, 5'd6),
                     1'b1, "jalr in slot 1");
        directedPair(rType(5'd5, 5'd1, 5'd2), iType(dualIssuePkg::opLui, 5'd3, 5'd5, 12'h0),
                     1'b0, "lui rs1 field");
        directedPair(rType(5'd5, 5'd1, 5'd2), rType(5'd6, 5'd7, 5'd8), 1'b0, "independent");
        directedPair(nop, nop, 1'b0, "nop pair");

        for (int n = 0; n < numRandom; n++) begin
            driveCycle(randInstr(), randInstr(),
                       wbPort(rngState[3], rngState[8:4], nextRand()),
                       wbPort(rngState[9], rngState[14:10], nextRand()));
        end

        repeat (2) @(posedge clk);
        $display("errors: ctrl %0d, data %0d, stall %0d", ctrlErrors, wordErrors, flagErrors);
        if (ctrlErrors + wordErrors + flagErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- dualDecode.f
src/dualIssuePkg.sv
src/instrControl.sv
src/immExtend.sv
src/regFile.sv
src/issueHazardUnit.sv
src/dualDecode.sv
bench/dualDecodeTb.sv

//--- run.sh
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timescale 1ns/1ns --top-module dualDecodeTb \
    -f dualDecode.f -o simv
./obj_dir/simv | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
